/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// base types
	//////////////////////////////////////////////////////////////////////

	// one machine word
	typedef logic [31:0] xlen_t;
	// architectural register index
	typedef logic [4:0] reg_idx_t;

	//////////////////////////////////////////////////////////////////////
	// encodings of the supported rv32 subset
	//////////////////////////////////////////////////////////////////////

	// major opcodes, full 7 bits incl. the 2'b11 length field
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// wfi is the only system instruction accepted
	localparam xlen_t WFI_ENCODING = 32'h1050_0073;

	// funct3 of the integer ops, shared by op-imm and op
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// funct7, alt selects sub / sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// alu operations
	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
	} alu_op_t;

	// status reported on the commit port
	typedef enum logic [1:0] {
		NO_ERROR,
		HALTED_ON_WFI,
		ILLEGAL_INST
	} error_status_t;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	import isa_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// stage payloads
	//////////////////////////////////////////////////////////////////////

	// decode -> execute
	typedef struct packed {
		xlen_t         pc;
		reg_idx_t      rs1;
		reg_idx_t      rs2;
		reg_idx_t      rd;
		logic          reg_write;
		alu_op_t       alu_op;
		// operand a from pc instead of rs1 (auipc)
		logic          use_pc_as_a;
		// operand b from imm instead of rs2
		logic          use_imm_as_b;
		xlen_t         imm;
		error_status_t status;
	} decoded_t;

	// execute -> commit
	typedef struct packed {
		reg_idx_t      rd;
		logic          reg_write;
		xlen_t         result;
		xlen_t         npc;
		error_status_t status;
	} result_t;

	// retired instruction counter
	typedef logic [15:0] count_t;

endpackage

`default_nettype wire

/* pipe_register.sv */
`default_nettype none
`timescale 1ns/100ps

module pipe_register #(
	parameter type payload_t = logic
) (
	input  wire      clock,
	input  wire      arst_n,
	input  wire      in_valid,
	output logic     in_ready,
	input  wire      payload_t in_data,
	output logic     out_valid,
	input  wire      out_ready,
	output payload_t out_data
);

	// accept when empty or when the held beat leaves this cycle
	assign in_ready = !out_valid || out_ready;

	// occupancy
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// payload loads only on an input beat
	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

	// producer holds a stalled beat until it is taken
	a_hold_stable: assert property (
		@(posedge clock) disable iff (!arst_n)
		in_valid && !in_ready |=> !in_valid || $stable(in_data)
	) else $error("pipe_register: input changed while stalled");

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none
`timescale 1ns/100ps

module register_file (
	input  wire              clock,
	input  wire              arst_n,
	input  wire              isa_pkg::reg_idx_t rd_idx_a,
	input  wire              isa_pkg::reg_idx_t rd_idx_b,
	output isa_pkg::xlen_t   rd_data_a,
	output isa_pkg::xlen_t   rd_data_b,
	input  wire              wr_en,
	input  wire              isa_pkg::reg_idx_t wr_idx,
	input  wire              isa_pkg::xlen_t wr_data
);

	import isa_pkg::*;

	// architectural registers
	xlen_t regs [32];

	//////////////////////////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////////////////////////

	// x0 never written
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read ports, combinational
	//////////////////////////////////////////////////////////////////////

	// x0 reads as zero
	assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

	a_wr_idx_known: assert property (
		@(posedge clock) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_idx)
	) else $error("register_file: unknown write index");

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
	input  wire               clock,
	input  wire               arst_n,
	input  wire               inst_valid,
	output logic              inst_ready,
	input  wire               isa_pkg::xlen_t inst,
	input  wire               isa_pkg::xlen_t inst_pc,
	output logic              dec_valid,
	input  wire               dec_ready,
	output pipe_pkg::decoded_t dec_data
);

	import isa_pkg::*;
	import pipe_pkg::*;

	decoded_t   dec_next;
	logic       illegal;
	logic       reg_in_ready;
	logic       halted;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// instruction fields
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		dec_next        = '0;
		dec_next.pc     = inst_pc;
		dec_next.rs1    = inst[19:15];
		dec_next.rs2    = inst[24:20];
		dec_next.rd     = inst[11:7];
		dec_next.alu_op = ADD;
		dec_next.status = NO_ERROR;
		illegal         = 1'b0;
		case (opcode)
			OP_IMM: begin
				dec_next.reg_write    = 1'b1;
				dec_next.use_imm_as_b = 1'b1;
				// i-type, sign extended
				dec_next.imm          = {{20{inst[31]}}, inst[31:20]};
				case (funct3)
					F3_ADD:  dec_next.alu_op = ADD;
					F3_SLT:  dec_next.alu_op = SLT;
					F3_SLTU: dec_next.alu_op = SLTU;
					F3_XOR:  dec_next.alu_op = XOR;
					F3_OR:   dec_next.alu_op = OR;
					F3_AND:  dec_next.alu_op = AND;
					F3_SLL: begin
						dec_next.alu_op = SLL;
						illegal         = (funct7 != F7_BASE);
					end
					F3_SR: begin
						// shamt in imm[4:0], funct7 picks arith
						dec_next.alu_op = (funct7 == F7_ALT) ? SRA : SRL;
						illegal         = (funct7 != F7_BASE) && (funct7 != F7_ALT);
					end
				endcase
			end
			OP_REG: begin
				dec_next.reg_write = 1'b1;
				case (funct3)
					F3_ADD:  dec_next.alu_op = (funct7 == F7_ALT) ? SUB : ADD;
					F3_SLL:  dec_next.alu_op = SLL;
					F3_SLT:  dec_next.alu_op = SLT;
					F3_SLTU: dec_next.alu_op = SLTU;
					F3_XOR:  dec_next.alu_op = XOR;
					F3_SR:   dec_next.alu_op = (funct7 == F7_ALT) ? SRA : SRL;
					F3_OR:   dec_next.alu_op = OR;
					F3_AND:  dec_next.alu_op = AND;
				endcase
				// alt funct7 only valid for sub and sra
				illegal = !((funct7 == F7_BASE) ||
					((funct7 == F7_ALT) && (funct3 == F3_ADD || funct3 == F3_SR)));
			end
			OP_LUI: begin
				dec_next.reg_write    = 1'b1;
				dec_next.alu_op       = PASS_B;
				dec_next.use_imm_as_b = 1'b1;
				dec_next.imm          = {inst[31:12], 12'b0};
			end
			OP_AUIPC: begin
				dec_next.reg_write    = 1'b1;
				dec_next.use_pc_as_a  = 1'b1;
				dec_next.use_imm_as_b = 1'b1;
				dec_next.imm          = {inst[31:12], 12'b0};
			end
			OP_SYSTEM: begin
				if (inst == WFI_ENCODING) begin
					dec_next.status = HALTED_ON_WFI;
				end else begin
					illegal = 1'b1;
				end
			end
			default: illegal = 1'b1;
		endcase
		// illegal never writes back
		if (illegal) begin
			dec_next.status    = ILLEGAL_INST;
			dec_next.reg_write = 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// halting gate
	//////////////////////////////////////////////////////////////////////

	// sticky once a wfi or illegal beat is taken
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			halted <= 1'b0;
		end else if (inst_valid && inst_ready && dec_next.status != NO_ERROR) begin
			halted <= 1'b1;
		end
	end

	assign inst_ready = reg_in_ready && !halted;

	pipe_register #(
		.payload_t(decoded_t)
	) dec_reg_i (
		.clock    (clock),
		.arst_n   (arst_n),
		.in_valid (inst_valid && !halted),
		.in_ready (reg_in_ready),
		.in_data  (dec_next),
		.out_valid(dec_valid),
		.out_ready(dec_ready),
		.out_data (dec_data)
	);

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
	input  wire                clock,
	input  wire                arst_n,
	input  wire                dec_valid,
	output logic               dec_ready,
	input  wire                pipe_pkg::decoded_t dec_data,
	output isa_pkg::reg_idx_t  rf_idx_a,
	output isa_pkg::reg_idx_t  rf_idx_b,
	input  wire                isa_pkg::xlen_t rf_data_a,
	input  wire                isa_pkg::xlen_t rf_data_b,
	output logic               exe_valid,
	input  wire                exe_ready,
	output pipe_pkg::result_t  exe_data
);

	import isa_pkg::*;
	import pipe_pkg::*;

	logic    fwd_a;
	logic    fwd_b;
	xlen_t   rs1_val;
	xlen_t   rs2_val;
	xlen_t   op_a;
	xlen_t   op_b;
	xlen_t   alu_result;
	result_t exe_next;

	//////////////////////////////////////////////////////////////////////
	// operand read
	//////////////////////////////////////////////////////////////////////

	assign rf_idx_a = dec_data.rs1;
	assign rf_idx_b = dec_data.rs2;

	// output register holds the only result not yet in the regfile
	// x0 never forwarded
	assign fwd_a = exe_valid && exe_data.reg_write && exe_data.rd != '0 &&
		exe_data.rd == dec_data.rs1;
	assign fwd_b = exe_valid && exe_data.reg_write && exe_data.rd != '0 &&
		exe_data.rd == dec_data.rs2;

	assign rs1_val = fwd_a ? exe_data.result : rf_data_a;
	assign rs2_val = fwd_b ? exe_data.result : rf_data_b;

	// operand muxes per decode flags
	assign op_a = dec_data.use_pc_as_a ? dec_data.pc : rs1_val;
	assign op_b = dec_data.use_imm_as_b ? dec_data.imm : rs2_val;

	//////////////////////////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (dec_data.alu_op)
			ADD:    alu_result = op_a + op_b;
			SUB:    alu_result = op_a - op_b;
			AND:    alu_result = op_a & op_b;
			OR:     alu_result = op_a | op_b;
			XOR:    alu_result = op_a ^ op_b;
			// shift amount is the low 5 bits only
			SLL:    alu_result = op_a << op_b[4:0];
			SRL:    alu_result = op_a >> op_b[4:0];
			SRA:    alu_result = xlen_t'($signed(op_a) >>> op_b[4:0]);
			SLT:    alu_result = xlen_t'($signed(op_a) < $signed(op_b));
			SLTU:   alu_result = xlen_t'(op_a < op_b);
			PASS_B: alu_result = op_b;
			default: alu_result = '0;
		endcase
	end

	// result payload, no branches so npc is always sequential
	always_comb begin
		exe_next.rd        = dec_data.rd;
		exe_next.reg_write = dec_data.reg_write;
		exe_next.result    = alu_result;
		exe_next.npc       = dec_data.pc + 32'd4;
		exe_next.status    = dec_data.status;
	end

	pipe_register #(
		.payload_t(result_t)
	) exe_reg_i (
		.clock    (clock),
		.arst_n   (arst_n),
		.in_valid (dec_valid),
		.in_ready (dec_ready),
		.in_data  (exe_next),
		.out_valid(exe_valid),
		.out_ready(exe_ready),
		.out_data (exe_data)
	);

endmodule

`default_nettype wire

/* commit_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module commit_stage (
	input  wire                    clock,
	input  wire                    arst_n,
	input  wire                    exe_valid,
	output logic                   exe_ready,
	input  wire                    pipe_pkg::result_t exe_data,
	output logic                   commit_valid,
	input  wire                    commit_ready,
	output logic                   commit_wr_en,
	output isa_pkg::reg_idx_t      commit_wr_idx,
	output isa_pkg::xlen_t         commit_wr_data,
	output isa_pkg::xlen_t         commit_npc,
	output pipe_pkg::count_t       commit_count,
	output isa_pkg::error_status_t error_status
);

	import isa_pkg::*;

	logic commit_beat;

	// head of the pipe is presented directly as the commit beat
	assign commit_valid = exe_valid;
	assign exe_ready    = commit_ready;
	assign commit_beat  = exe_valid && commit_ready;

	// regfile write only on the beat itself
	// x0 filtered in the regfile
	assign commit_wr_en   = commit_beat && exe_data.reg_write;
	assign commit_wr_idx  = exe_data.rd;
	assign commit_wr_data = exe_data.result;
	assign commit_npc     = exe_data.npc;

	//////////////////////////////////////////////////////////////////////
	// retire count and error status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			commit_count <= '0;
			error_status <= NO_ERROR;
		end else if (commit_beat) begin
			commit_count <= commit_count + 1'b1;
			// first halting status sticks until reset
			if (error_status == NO_ERROR) begin
				error_status <= exe_data.status;
			end
		end
	end

	// decode blocks after the halting beat, so nothing trails it
	a_no_commit_after_halt: assert property (
		@(posedge clock) disable iff (!arst_n)
		error_status != NO_ERROR |-> !commit_valid
	) else $error("commit_stage: commit after halt");

endmodule

`default_nettype wire

/* rv_pipeline.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_pipeline (
	input  wire                    clock,
	input  wire                    arst_n,
	// instruction input
	input  wire                    inst_valid,
	output logic                   inst_ready,
	input  wire                    isa_pkg::xlen_t inst,
	input  wire                    isa_pkg::xlen_t inst_pc,
	// commit port
	output logic                   commit_valid,
	input  wire                    commit_ready,
	output logic                   commit_wr_en,
	output isa_pkg::reg_idx_t      commit_wr_idx,
	output isa_pkg::xlen_t         commit_wr_data,
	output isa_pkg::xlen_t         commit_npc,
	output pipe_pkg::count_t       commit_count,
	output isa_pkg::error_status_t error_status
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// decode -> execute
	logic     dec_valid;
	logic     dec_ready;
	decoded_t dec_data;

	// execute -> commit
	logic     exe_valid;
	logic     exe_ready;
	result_t  exe_data;

	// regfile read side
	reg_idx_t rf_idx_a;
	reg_idx_t rf_idx_b;
	xlen_t    rf_data_a;
	xlen_t    rf_data_b;

	//////////////////////////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////////////////////////

	decode_stage decode_i (
		.clock     (clock),
		.arst_n    (arst_n),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst      (inst),
		.inst_pc   (inst_pc),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec_data  (dec_data)
	);

	execute_stage execute_i (
		.clock    (clock),
		.arst_n   (arst_n),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_data (dec_data),
		.rf_idx_a (rf_idx_a),
		.rf_idx_b (rf_idx_b),
		.rf_data_a(rf_data_a),
		.rf_data_b(rf_data_b),
		.exe_valid(exe_valid),
		.exe_ready(exe_ready),
		.exe_data (exe_data)
	);

	// exe_ready is commit_ready passed back through commit
	commit_stage commit_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.exe_valid     (exe_valid),
		.exe_ready     (exe_ready),
		.exe_data      (exe_data),
		.commit_valid  (commit_valid),
		.commit_ready  (commit_ready),
		.commit_wr_en  (commit_wr_en),
		.commit_wr_idx (commit_wr_idx),
		.commit_wr_data(commit_wr_data),
		.commit_npc    (commit_npc),
		.commit_count  (commit_count),
		.error_status  (error_status)
	);

	// write side shared with the commit port
	register_file regfile_i (
		.clock    (clock),
		.arst_n   (arst_n),
		.rd_idx_a (rf_idx_a),
		.rd_idx_b (rf_idx_b),
		.rd_data_a(rf_data_a),
		.rd_data_b(rf_data_b),
		.wr_en    (commit_wr_en),
		.wr_idx   (commit_wr_idx),
		.wr_data  (commit_wr_data)
	);

endmodule

`default_nettype wire

/* tb_rv_pipeline.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_rv_pipeline;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CLK_PERIOD  = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int HALT_WAIT   = 20;

	// instructions sent by each directed test
	localparam int N_ALU = 24;
	localparam int N_FWD = 7;
	localparam int N_BP  = 30;
	localparam int N_WFI = 2;
	localparam int N_ILL = 2;
	localparam int TOTAL_INSTS    = N_ALU + N_FWD + N_BP + N_WFI + N_ILL;
	localparam int TIMEOUT_CYCLES = 4 * TOTAL_INSTS + 100;

	logic             clock;
	logic             arst_n;
	logic             inst_valid;
	logic             inst_ready;
	xlen_t            inst;
	xlen_t            inst_pc;
	logic             commit_valid;
	logic             commit_ready = 1'b1;
	logic             commit_wr_en;
	reg_idx_t         commit_wr_idx;
	xlen_t            commit_wr_data;
	xlen_t            commit_npc;
	count_t           commit_count;
	error_status_t    error_status;

	// reference model state
	xlen_t    model_regs [32];
	xlen_t    next_pc;
	// predicted commits, oldest first
	logic     exp_wr_q [$];
	reg_idx_t exp_idx_q [$];
	xlen_t    exp_data_q [$];
	xlen_t    exp_npc_q [$];
	// monitor side
	logic     e_wr;
	reg_idx_t e_idx;
	xlen_t    e_data;
	xlen_t    e_npc;
	count_t   beats;
	// back-pressure source
	logic     bp_on = 1'b0;
	integer   bp_seed = 28;
	logic [31:0] rnd;
	int       cycle_count = 0;

	rv_pipeline dut_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.inst_valid    (inst_valid),
		.inst_ready    (inst_ready),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.commit_valid  (commit_valid),
		.commit_ready  (commit_ready),
		.commit_wr_en  (commit_wr_en),
		.commit_wr_idx (commit_wr_idx),
		.commit_wr_data(commit_wr_data),
		.commit_npc    (commit_npc),
		.commit_count  (commit_count),
		.error_status  (error_status)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// failure reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_status(input string name, input error_status_t got,
		input error_status_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// encoders and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic xlen_t i_type(input logic [2:0] f3, input reg_idx_t rd,
		input reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, OP_IMM};
	endfunction

	function automatic xlen_t r_type(input logic [6:0] f7, input logic [2:0] f3,
		input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic xlen_t u_type(input logic [6:0] opc, input reg_idx_t rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	// rv32 semantics straight from the spec, x0 stays zero
	task automatic predict_commit(input xlen_t word, input xlen_t pc);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		reg_idx_t   rd;
		xlen_t      a;
		xlen_t      b;
		xlen_t      imm;
		xlen_t      res;
		logic       writes;
		opc    = word[6:0];
		f3     = word[14:12];
		f7     = word[31:25];
		rd     = word[11:7];
		a      = model_regs[word[19:15]];
		b      = model_regs[word[24:20]];
		imm    = {{20{word[31]}}, word[31:20]};
		res    = '0;
		writes = 1'b0;
		case (opc)
			OP_IMM: begin
				writes = 1'b1;
				// register-register ops reuse the same funct3 table, b is the immediate
				b = imm;
			end
			OP_REG: begin
				writes = (f7 == F7_BASE) ||
					((f7 == F7_ALT) && (f3 == F3_ADD || f3 == F3_SR));
			end
			OP_LUI: begin
				writes = 1'b1;
				res    = {word[31:12], 12'h000};
			end
			OP_AUIPC: begin
				writes = 1'b1;
				res    = pc + {word[31:12], 12'h000};
			end
			default: writes = 1'b0;
		endcase
		if (opc == OP_IMM || opc == OP_REG) begin
			case (f3)
				F3_ADD: begin
					if (opc == OP_REG && f7 == F7_ALT) res = a - b;
					else res = a + b;
				end
				F3_SLL:  res = a << b[4:0];
				F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
				F3_XOR:  res = a ^ b;
				F3_OR:   res = a | b;
				F3_AND:  res = a & b;
				default: begin
					// funct7 bit 5 picks arithmetic right shift
					if (f7 == F7_ALT) res = $signed(a) >>> b[4:0];
					else res = a >> b[4:0];
				end
			endcase
			// shift immediates carry a funct7 too
			if (opc == OP_IMM && f3 == F3_SLL) writes = (f7 == F7_BASE);
			if (opc == OP_IMM && f3 == F3_SR) writes = (f7 == F7_BASE) || (f7 == F7_ALT);
		end
		if (writes && rd != '0) begin
			model_regs[rd] = res;
		end
		exp_wr_q.push_back(writes);
		exp_idx_q.push_back(rd);
		exp_data_q.push_back(res);
		exp_npc_q.push_back(pc + 32'd4);
	endtask

	//////////////////////////////////////////////////////////////////////
	// drivers, monitor, timeout
	//////////////////////////////////////////////////////////////////////

	// callers sit a drive delay after a rising edge
	task automatic send_inst(input xlen_t word);
		predict_commit(word, next_pc);
		inst       = word;
		inst_pc    = next_pc;
		inst_valid = 1'b1;
		@(negedge clock);
		while (!inst_ready) @(negedge clock);
		@(posedge clock);
		#DRIVE_DELAY;
		inst_valid = 1'b0;
		next_pc    = next_pc + 32'd4;
	endtask

	task automatic wait_drain();
		while (exp_npc_q.size() != 0) @(negedge clock);
		@(posedge clock);
		#DRIVE_DELAY;
		check_count("commit_count", commit_count, beats);
	endtask

	task automatic apply_reset();
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		repeat (4) @(posedge clock);
		#DRIVE_DELAY;
		arst_n  = 1'b1;
		next_pc = 32'h0000_1000;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		@(negedge clock);
		check_flag("inst_ready", inst_ready, 1'b1);
		check_flag("commit_valid", commit_valid, 1'b0);
		check_flag("commit_wr_en", commit_wr_en, 1'b0);
		check_count("commit_count", commit_count, '0);
		check_status("error_status", error_status, NO_ERROR);
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	// offer one more instruction, none may enter or retire
	task automatic hold_while_halted(input error_status_t exp_st);
		check_status("error_status", error_status, exp_st);
		inst       = i_type(F3_ADD, 5'd9, 5'd9, 12'd1);
		inst_pc    = next_pc;
		inst_valid = 1'b1;
		repeat (HALT_WAIT) begin
			@(negedge clock);
			check_flag("inst_ready", inst_ready, 1'b0);
		end
		@(posedge clock);
		#DRIVE_DELAY;
		inst_valid = 1'b0;
		check_status("error_status", error_status, exp_st);
		check_count("commit_count", commit_count, beats);
	endtask

	// commit beats compared at the falling edge, all inputs settled
	always @(negedge clock) begin
		if (!arst_n) begin
			beats = '0;
		end else if (commit_valid && commit_ready) begin
			if (exp_npc_q.size() == 0) begin
				$display("commit beat at %0t with no instruction outstanding", $time);
				stop_with_failure();
			end else begin
				e_wr   = exp_wr_q.pop_front();
				e_idx  = exp_idx_q.pop_front();
				e_data = exp_data_q.pop_front();
				e_npc  = exp_npc_q.pop_front();
				check_word("commit_npc", commit_npc, e_npc);
				check_flag("commit_wr_en", commit_wr_en, e_wr);
				if (e_wr) begin
					check_idx("commit_wr_idx", commit_wr_idx, e_idx);
					check_word("commit_wr_data", commit_wr_data, e_data);
				end
				beats = beats + 16'd1;
			end
		end
	end

	// commit_ready toggles at random only while back-pressure is on
	always @(posedge clock) begin
		#DRIVE_DELAY;
		if (bp_on) begin
			rnd          = $random(bp_seed);
			commit_ready = rnd[0];
		end else begin
			commit_ready = 1'b1;
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic alu_ops();
		send_inst(i_type(F3_ADD, 5'd1, 5'd0, 12'hff9));
		send_inst(i_type(F3_ADD, 5'd2, 5'd0, 12'd13));
		send_inst(i_type(F3_ADD, 5'd3, 5'd0, 12'd3));
		// op-imm
		send_inst(i_type(F3_ADD, 5'd4, 5'd1, 12'd100));
		send_inst(i_type(F3_SLT, 5'd5, 5'd1, 12'd5));
		send_inst(i_type(F3_SLTU, 5'd6, 5'd1, 12'd5));
		send_inst(i_type(F3_XOR, 5'd7, 5'd2, 12'h5a5));
		send_inst(i_type(F3_OR, 5'd8, 5'd2, 12'h700));
		send_inst(i_type(F3_AND, 5'd9, 5'd1, 12'h0f0));
		send_inst(i_type(F3_SLL, 5'd10, 5'd2, 12'h007));
		send_inst(i_type(F3_SR, 5'd11, 5'd1, 12'h004));
		send_inst(i_type(F3_SR, 5'd12, 5'd1, 12'h404));
		// op
		send_inst(r_type(F7_BASE, F3_ADD, 5'd13, 5'd1, 5'd2));
		send_inst(r_type(F7_ALT, F3_ADD, 5'd14, 5'd1, 5'd2));
		send_inst(r_type(F7_BASE, F3_SLL, 5'd15, 5'd2, 5'd3));
		send_inst(r_type(F7_BASE, F3_SLT, 5'd16, 5'd1, 5'd2));
		send_inst(r_type(F7_BASE, F3_SLTU, 5'd17, 5'd1, 5'd2));
		send_inst(r_type(F7_BASE, F3_XOR, 5'd18, 5'd1, 5'd2));
		send_inst(r_type(F7_BASE, F3_SR, 5'd19, 5'd1, 5'd3));
		send_inst(r_type(F7_ALT, F3_SR, 5'd20, 5'd1, 5'd3));
		send_inst(r_type(F7_BASE, F3_OR, 5'd21, 5'd1, 5'd2));
		send_inst(r_type(F7_BASE, F3_AND, 5'd22, 5'd1, 5'd2));
		// upper immediates
		send_inst(u_type(OP_LUI, 5'd23, 20'habcde));
		send_inst(u_type(OP_AUIPC, 5'd24, 20'h12345));
		wait_drain();
	endtask

	task automatic forwarding();
		send_inst(i_type(F3_ADD, 5'd1, 5'd0, 12'd5));
		send_inst(i_type(F3_ADD, 5'd1, 5'd1, 12'd3));
		send_inst(r_type(F7_BASE, F3_ADD, 5'd2, 5'd1, 5'd1));
		send_inst(r_type(F7_ALT, F3_ADD, 5'd3, 5'd2, 5'd1));
		// x0 target, written value must not come back
		send_inst(i_type(F3_ADD, 5'd0, 5'd2, 12'd9));
		send_inst(r_type(F7_BASE, F3_ADD, 5'd4, 5'd0, 5'd3));
		send_inst(r_type(F7_BASE, F3_OR, 5'd5, 5'd0, 5'd0));
		wait_drain();
	endtask

	task automatic back_pressure();
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [11:0] imm;
		bp_on = 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			// short register window keeps most operands dependent
			rd  = reg_idx_t'(1 + (i % 7));
			rs1 = reg_idx_t'(1 + ((i + 6) % 7));
			rs2 = reg_idx_t'(1 + ((i + 5) % 7));
			imm = 12'(i * 173);
			case (i % 3)
				0: send_inst(i_type(F3_ADD, rd, rs1, imm));
				1: send_inst(r_type(F7_BASE, F3_ADD, rd, rs1, rs2));
				default: send_inst(r_type(F7_BASE, F3_XOR, rd, rs1, rs2));
			endcase
		end
		wait_drain();
		bp_on = 1'b0;
	endtask

	task automatic wfi_halt();
		send_inst(i_type(F3_ADD, 5'd9, 5'd9, 12'd1));
		send_inst(WFI_ENCODING);
		wait_drain();
		hold_while_halted(HALTED_ON_WFI);
	endtask

	task automatic illegal_halt();
		apply_reset();
		// x13 was non-zero before the reset
		send_inst(i_type(F3_ADD, 5'd10, 5'd13, 12'd0));
		// beq decodes as illegal
		send_inst(32'h0000_0063);
		wait_drain();
		hold_while_halted(ILLEGAL_INST);
	endtask

	initial begin
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		inst_pc    = '0;
		apply_reset();
		alu_ops();
		forwarding();
		back_pressure();
		wfi_halt();
		illegal_halt();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
isa_pkg.sv
pipe_pkg.sv
pipe_register.sv
register_file.sv
decode_stage.sv
execute_stage.sv
commit_stage.sv
rv_pipeline.sv
tb_rv_pipeline.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_rv_pipeline \
	-f verilog.f \
	-o sim_rv_pipeline
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_rv_pipeline > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
